//--- include/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Cache geometry
`define CACHE_WORD_W   32
`define CACHE_WORDS    4
`define CACHE_WAYS     4
`define CACHE_SETS     16

// Word address split
`define CACHE_TAG_W    26
`define CACHE_INDEX_W  4
`define CACHE_OFFSET_W 2

`endif

//--- logic/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

    typedef logic [`CACHE_WORD_W-1:0]           word_t;
    typedef logic [`CACHE_WORDS-1:0][`CACHE_WORD_W-1:0] block_t;  // Word 0 in the low bits
    typedef logic [`CACHE_TAG_W-1:0]            tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]          index_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0]     way_t;

    typedef struct packed {
        tag_t                       tag;
        index_t                     index;
        logic [`CACHE_OFFSET_W-1:0] offset;  // Word within the block
    } addr_t;

    typedef struct packed {
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic  valid;
        logic  write;  // 1 = store
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } cpu_rsp_t;

    // Block request towards memory
    typedef struct packed {
        logic   rd;
        logic   wr;
        tag_t   tag;
        index_t index;
        block_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic                          hit;
        way_t                          hit_way;
        logic                          free;      // Some way of the set is invalid
        way_t                          free_way;  // Lowest invalid way
        logic [`CACHE_WAYS-1:0]        dirty;     // Valid and dirty per way
        tag_t [`CACHE_WAYS-1:0]        tags;
    } lookup_t;

endpackage

//--- logic/way_array.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module way_array #(
    parameter type entry_t = logic
) (
    input  logic              clk,
    input  cache_pkg::index_t index,
    input  logic              we,
    input  cache_pkg::way_t   way,
    input  entry_t            wdata,
    output entry_t            rdata [`CACHE_WAYS]
);

    entry_t mem [`CACHE_SETS][`CACHE_WAYS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index][way] <= wdata;
        end
    end

    // Whole set visible in the same cycle
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            rdata[w] = mem[index][w];
        end
    end

endmodule

//--- logic/way_lookup.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module way_lookup (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::index_t     index,
    input  cache_pkg::tag_t       tag,
    input  logic                  tag_we,
    input  cache_pkg::way_t       wr_way,
    input  cache_pkg::tag_entry_t wr_entry,
    output cache_pkg::lookup_t    lookup
);
    import cache_pkg::*;

    logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] valid_q;
    logic [`CACHE_WAYS-1:0]                  set_valid;
    tag_entry_t                              entries [`CACHE_WAYS];

    way_array #(
        .entry_t(tag_entry_t)
    ) u_tag_array (
        .clk  (clk),
        .index(index),
        .we   (tag_we),
        .way  (wr_way),
        .wdata(wr_entry),
        .rdata(entries)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (tag_we) begin
            valid_q[index][wr_way] <= 1'b1;  // Any tag write makes the way live
        end
    end

    assign set_valid = valid_q[index];

    always_comb begin
        lookup = '0;
        // Descending scan leaves the lowest invalid way
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                lookup.free     = 1'b1;
                lookup.free_way = way_t'(w);
            end
        end
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            lookup.dirty[w] = set_valid[w] && entries[w].dirty;
            lookup.tags[w]  = entries[w].tag;
            if (set_valid[w] && entries[w].tag == tag) begin
                lookup.hit     = 1'b1;
                lookup.hit_way = way_t'(w);
            end
        end
    end

endmodule

//--- logic/plru_tree.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module plru_tree (
    input  logic              clk,
    input  logic              rst,
    input  cache_pkg::index_t index,
    input  logic              touch,
    input  cache_pkg::way_t   touch_way,
    output cache_pkg::way_t   victim
);

    // Per set {root, left, right}
    logic [`CACHE_SETS-1:0][2:0] tree_q;
    logic [2:0]                  cur_bits;
    logic [2:0]                  next_bits;

    assign cur_bits = tree_q[index];

    always_comb begin
        if (!cur_bits[2]) begin
            victim = cur_bits[1] ? 2'd1 : 2'd0;  // Left pair
        end else begin
            victim = cur_bits[0] ? 2'd3 : 2'd2;  // Right pair
        end
    end

    // Point the tree away from the way just used
    always_comb begin
        next_bits = cur_bits;
        if (!touch_way[1]) begin
            next_bits[2] = 1'b1;
            next_bits[1] = ~touch_way[0];
        end else begin
            next_bits[2] = 1'b0;
            next_bits[0] = ~touch_way[0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tree_q <= '0;
        end else if (touch) begin
            tree_q[index] <= next_bits;
        end
    end

endmodule

//--- logic/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::cpu_req_t   cpu_req,
    output cache_pkg::cpu_rsp_t   cpu_rsp,
    input  cache_pkg::lookup_t    lookup,
    input  cache_pkg::way_t       victim,
    output cache_pkg::index_t     index,
    output cache_pkg::tag_t       tag,
    output logic                  tag_we,
    output cache_pkg::way_t       wr_way,
    output cache_pkg::tag_entry_t wr_entry,
    output logic                  data_we,
    output cache_pkg::block_t     data_wdata,
    input  cache_pkg::block_t     set_blocks [`CACHE_WAYS],
    output logic                  touch,
    output cache_pkg::way_t       touch_way,
    output cache_pkg::mem_req_t   mem_req,
    input  cache_pkg::block_t     mem_rdata,
    input  logic                  mem_valid,
    input  logic                  mem_ready
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        WRITE_BACK,
        REFILL,
        RESPOND
    } state_t;

    state_t   state_q;
    state_t   state_d;
    cpu_req_t req_q;
    way_t     way_q;     // Target way after the compare cycle
    way_t     sel_way;
    block_t   sel_block;
    block_t   merged_block;

    assign index = req_q.addr.index;
    assign tag   = req_q.addr.tag;

    // Hit way is only known live during compare
    assign sel_way   = (state_q == COMPARE) ? lookup.hit_way : way_q;
    assign sel_block = set_blocks[sel_way];

    always_comb begin
        merged_block                    = sel_block;
        merged_block[req_q.addr.offset] = req_q.wdata;
    end

    assign touch     = cpu_rsp.done;
    assign touch_way = sel_way;

    always_comb begin
        state_d       = state_q;
        cpu_rsp.done  = 1'b0;
        cpu_rsp.rdata = sel_block[req_q.addr.offset];
        tag_we        = 1'b0;
        data_we       = 1'b0;
        wr_way        = sel_way;
        wr_entry      = '{dirty: 1'b1, tag: req_q.addr.tag};
        data_wdata    = merged_block;
        mem_req.rd    = 1'b0;
        mem_req.wr    = 1'b0;
        mem_req.tag   = req_q.addr.tag;
        mem_req.index = req_q.addr.index;
        mem_req.wdata = sel_block;  // Victim block during write-back
        case (state_q)
            IDLE: begin
                if (cpu_req.valid) state_d = COMPARE;
            end
            COMPARE: begin
                if (lookup.hit) begin
                    cpu_rsp.done = 1'b1;
                    tag_we       = req_q.write;  // Store marks the line dirty
                    data_we      = req_q.write;
                    state_d      = IDLE;
                end else if (!lookup.free && lookup.dirty[victim]) begin
                    state_d = WRITE_BACK;
                end else begin
                    state_d = REFILL;
                end
            end
            WRITE_BACK: begin
                mem_req.wr  = 1'b1;
                mem_req.tag = lookup.tags[way_q];  // Old owner of the line
                if (mem_ready) state_d = REFILL;
            end
            REFILL: begin
                mem_req.rd     = 1'b1;
                wr_entry.dirty = 1'b0;
                data_wdata     = mem_rdata;
                if (mem_valid) begin
                    tag_we  = 1'b1;
                    data_we = 1'b1;
                    state_d = RESPOND;
                end
            end
            RESPOND: begin
                cpu_rsp.done = 1'b1;
                tag_we       = req_q.write;
                data_we      = req_q.write;
                state_d      = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && cpu_req.valid) begin
            req_q <= cpu_req;
        end
        if (state_q == COMPARE) begin
            if (lookup.hit)       way_q <= lookup.hit_way;
            else if (lookup.free) way_q <= lookup.free_way;
            else                  way_q <= victim;  // Full set falls back to the tree
        end
    end

endmodule

//--- logic/cache_top.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_top (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::cpu_req_t cpu_req,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::block_t   mem_rdata,
    input  logic                mem_valid,
    input  logic                mem_ready
);
    import cache_pkg::*;

    index_t     index;
    tag_t       tag;
    logic       tag_we;
    way_t       wr_way;
    tag_entry_t wr_entry;
    logic       data_we;
    block_t     data_wdata;
    block_t     set_blocks [`CACHE_WAYS];
    logic       touch;
    way_t       touch_way;
    lookup_t    lookup;
    way_t       victim;

    way_lookup u_way_lookup (
        .clk     (clk),
        .rst     (rst),
        .index   (index),
        .tag     (tag),
        .tag_we  (tag_we),
        .wr_way  (wr_way),
        .wr_entry(wr_entry),
        .lookup  (lookup)
    );

    plru_tree u_plru_tree (
        .clk      (clk),
        .rst      (rst),
        .index    (index),
        .touch    (touch),
        .touch_way(touch_way),
        .victim   (victim)
    );

    // Data blocks share the way select with the tags
    way_array #(
        .entry_t(block_t)
    ) u_data_array (
        .clk  (clk),
        .index(index),
        .we   (data_we),
        .way  (wr_way),
        .wdata(data_wdata),
        .rdata(set_blocks)
    );

    cache_ctrl u_cache_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .lookup    (lookup),
        .victim    (victim),
        .index     (index),
        .tag       (tag),
        .tag_we    (tag_we),
        .wr_way    (wr_way),
        .wr_entry  (wr_entry),
        .data_we   (data_we),
        .data_wdata(data_wdata),
        .set_blocks(set_blocks),
        .touch     (touch),
        .touch_way (touch_way),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready)
    );

endmodule

//--- verif/cache_assert.sv
`timescale 1ns/1ps

module cache_assert (
    input logic                clk,
    input logic                rst,
    input cache_pkg::cpu_rsp_t cpu_rsp,
    input cache_pkg::mem_req_t mem_req,
    input logic                mem_ready
);

    int unsigned fail_count = 0;

    // One cycle per response
    done_single: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp.done |=> !cpu_rsp.done)
    else begin
        $error("done stayed high for two cycles");
        fail_count++;
    end

    strobes_apart: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.rd && mem_req.wr))
    else begin
        $error("memory read and write strobes high together");
        fail_count++;
    end

    // Write-back held until the memory takes it
    wb_hold: assert property (@(posedge clk) disable iff (rst)
        (mem_req.wr && !mem_ready) |=> mem_req.wr && $stable(mem_req.tag)
            && $stable(mem_req.index) && $stable(mem_req.wdata))
    else begin
        $error("write-back request changed before mem_ready");
        fail_count++;
    end

endmodule

bind cache_top cache_assert u_cache_assert (
    .clk      (clk),
    .rst      (rst),
    .cpu_rsp  (cpu_rsp),
    .mem_req  (mem_req),
    .mem_ready(mem_ready)
);

//--- verif/cache_tb.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tb;
    import cache_pkg::*;

    typedef struct {
        int    op;    // 0 read, 1 write, 2 read that must hit, 3 read with write-back
        word_t addr;
        word_t data;  // Write word, or the evicted block address for op 3
        int    lat;
    } stim_t;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    cpu_req_t cpu_req = '0;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    block_t   mem_rdata = '0;
    logic     mem_valid = 1'b0;
    logic     mem_ready = 1'b0;

    stim_t    stim_q [$];
    mem_req_t wb_log [$];  // Write-backs of the current operation
    word_t    mem_words [word_t];
    word_t    shadow [word_t];
    int       cur_lat;
    int       mem_wait;
    bit       mem_busy;
    bit       stim_ready;

    cache_top u_cache_top (
        .clk      (clk),
        .rst      (rst),
        .cpu_req  (cpu_req),
        .cpu_rsp  (cpu_rsp),
        .mem_req  (mem_req),
        .mem_rdata(mem_rdata),
        .mem_valid(mem_valid),
        .mem_ready(mem_ready)
    );

    always #4 clk = ~clk;

    function automatic word_t initial_word(word_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic word_t expected_word(word_t a);
        return shadow.exists(a) ? shadow[a] : initial_word(a);
    endfunction

    function automatic word_t memory_word(word_t a);
        return mem_words.exists(a) ? mem_words[a] : initial_word(a);
    endfunction

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR %s got %h expected %h", name, got, exp));
        end
    endtask

    // Block address only, the offset of exp is ignored
    task automatic check_mem(string name, mem_req_t got, addr_t exp);
        if ({got.tag, got.index} !== {exp.tag, exp.index}) begin
            stop_with_failure($sformatf("ERROR %s block address got %h expected %h",
                name, {got.tag, got.index}, {exp.tag, exp.index}));
        end
    endtask

    task automatic load_stim();
        int              fd;
        int              n;
        logic [8*96-1:0] line;
        stim_t           s;
        fd = $fopen("verif/cache_stim.txt", "r");
        if (fd == 0) stop_with_failure("Could not open verif/cache_stim.txt");
        while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            // Comment and blank lines do not scan
            if (n > 0 && $sscanf(line, "%h %h %h %d", s.op, s.addr, s.data, s.lat) == 4) begin
                stim_q.push_back(s);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_op(stim_t s);
        int    cycles;
        word_t rdata;
        cur_lat = (s.lat == 0) ? int'($urandom % 4) : s.lat;
        wb_log.delete();
        cpu_req <= '{valid: 1'b1, write: (s.op == 1), addr: addr_t'(s.addr), wdata: s.data};
        @(posedge clk);  // Accepted here
        cpu_req.valid <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!cpu_rsp.done);
        rdata = cpu_rsp.rdata;
        if (s.op == 1) begin
            shadow[s.addr] = s.data;
        end else begin
            if (s.op == 2 && cycles != 1) begin
                stop_with_failure($sformatf("Read of %h took %0d cycles to done instead of 1",
                    s.addr, cycles));
            end
            if (s.op == 3) begin
                if (wb_log.size() != 1) begin
                    stop_with_failure($sformatf("Read of %h caused %0d write-backs instead of 1",
                        s.addr, wb_log.size()));
                end
                check_mem("mem_req", wb_log[0], addr_t'(s.data));
            end
            check_word("cpu_rsp.rdata", rdata, expected_word(s.addr));
        end
    endtask

    // Memory model, one answer per held strobe
    always @(posedge clk) begin
        block_t blk;
        if (rst) begin
            mem_valid <= 1'b0;
            mem_ready <= 1'b0;
            mem_busy = 1'b0;
        end else if (mem_valid || mem_ready) begin
            mem_valid <= 1'b0;  // Answer taken at this edge
            mem_ready <= 1'b0;
            mem_busy = 1'b0;
        end else if (mem_req.rd || mem_req.wr) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = cur_lat;
            end
            if (mem_wait != 0) begin
                mem_wait--;
            end else if (mem_req.wr) begin
                for (int w = 0; w < `CACHE_WORDS; w++) begin
                    mem_words[{mem_req.tag, mem_req.index, `CACHE_OFFSET_W'(w)}] = mem_req.wdata[w];
                end
                wb_log.push_back(mem_req);
                mem_ready <= 1'b1;
            end else begin
                for (int w = 0; w < `CACHE_WORDS; w++) begin
                    blk[w] = memory_word({mem_req.tag, mem_req.index, `CACHE_OFFSET_W'(w)});
                end
                mem_rdata <= blk;
                mem_valid <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (u_cache_top.u_cache_assert.fail_count != 0) begin
            stop_with_failure("A protocol assertion on the cache ports fired");
        end
    end

    initial begin
        int limit;
        wait (stim_ready);
        limit = stim_q.size() * 40 + 10;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the stimulus finished", limit);
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'hc6b5_b82c));
        load_stim();
        stim_ready = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag("cpu_rsp.done", cpu_rsp.done, 1'b0);
        check_flag("mem_req.rd", mem_req.rd, 1'b0);
        check_flag("mem_req.wr", mem_req.wr, 1'b0);
        foreach (stim_q[i]) begin
            run_op(stim_q[i]);
        end
        if (u_cache_top.u_cache_assert.fail_count != 0) begin
            stop_with_failure("A protocol assertion on the cache ports fired");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

//--- verif/cache_stim.txt
# op addr wdata lat; op 0 read, 1 write, 2 read that must hit, 3 read that writes back block wdata
# lat is the memory delay in cycles, 0 picks a random delay of 0 to 3
0 00000044 00000000 2
2 00000045 00000000 1
1 00000046 deadbeef 3
2 00000046 00000000 1
2 00000047 00000000 1
1 00000048 11110001 1
1 00000089 22220002 2
1 000000ca 33330003 1
1 0000010b 44440004 3
3 00000148 00000048 2
3 00000048 000000c8 1
1 00000155 a5a5a5a5 0
1 00000196 5a5a5a5a 0
1 000001d7 0f0f0f0f 0
1 00000214 f0f0f0f0 0
1 00000255 12345678 0
0 00000155 00000000 0
0 000001d7 00000000 0
0 00000256 00000000 0

//--- all.f
+incdir+include
logic/cache_pkg.sv
logic/way_array.sv
logic/way_lookup.sv
logic/plru_tree.sv
logic/cache_ctrl.sv
logic/cache_top.sv
verif/cache_assert.sv
verif/cache_tb.sv

//--- Makefile
SIM  = obj_dir/Vcache_tb
SRCS = $(filter-out +%,$(shell cat all.f))

.PHONY: run check clean

run: $(SIM)
	-./$(SIM) +verilator+error+limit+100 > sim.log 2>&1
	@cat sim.log
	@! grep -q "Test failed" sim.log
	@grep -q "Test passed" sim.log

check:
	@! grep -q "Test failed" sim.log
	@grep -q "Test passed" sim.log

$(SIM): all.f $(SRCS) include/cache_cfg.svh
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module cache_tb -f all.f

clean:
	rm -rf obj_dir sim.log
